//--- Makefile
VERILATOR ?= verilator
TOP       ?= fdiv_tb
FILELIST  ?= fdiv.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- fdiv.f
src/fdiv_pkg.sv
src/fdiv_pipe_regs.sv
src/fdiv_classify.sv
src/fdiv_mant_divider.sv
src/fdiv_round_pack.sv
src/fdiv_ctrl.sv
src/fdiv_top.sv
test/fdiv_chk.sv
test/fdiv_tb.sv

//--- src/fdiv_classify.sv
/*
  operand classification for the divider
  zero (subnormals included), infinity, quiet and signaling nan
  special result and flags for nan, zero and infinity operands
*/

`timescale 1ns/100ps

module fdiv_classify import fdiv_pkg::*; (
  input  fp32_t   a_i, // dividend
  input  fp32_t   b_i, // divisor
  output logic    special_o,
  output fp32_t   special_result_o,
  output status_t special_status_o
);

  fp32_t      ops [2];
  logic [1:0] is_zero, is_inf, is_qnan, is_snan;
  logic       any_nan, zero_zero, inf_inf, sign;

  assign ops[0] = a_i;
  assign ops[1] = b_i;

  // same decode for both operands
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      is_zero[i] = ops[i][WIDTH-2 -: EXP_W] == '0; // subnormal counts as zero
      is_inf[i]  = (&ops[i][WIDTH-2 -: EXP_W]) && ops[i][MAN_W-1:0] == '0;
      is_qnan[i] = (&ops[i][WIDTH-2 -: EXP_W]) && ops[i][MAN_W-1];
      is_snan[i] = (&ops[i][WIDTH-2 -: EXP_W]) && !ops[i][MAN_W-1]
                   && ops[i][MAN_W-2:0] != '0;
    end
  end

  assign any_nan   = |{is_qnan, is_snan};
  assign zero_zero = &is_zero;  // 0/0
  assign inf_inf   = &is_inf;   // inf/inf
  assign sign      = a_i[WIDTH-1] ^ b_i[WIDTH-1];

  always_comb begin
    special_o        = 1'b1;
    special_result_o = CANON_NAN;
    special_status_o = '0;
    if (any_nan || zero_zero || inf_inf) begin
      special_status_o[4] = |is_snan || zero_zero || inf_inf; // nv
    end else if (is_inf[0]) begin
      special_result_o = {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}}; // inf / finite
    end else if (is_zero[1]) begin
      special_result_o    = {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
      special_status_o[3] = 1'b1; // dz
    end else if (is_zero[0] || is_inf[1]) begin
      special_result_o = {sign, {(WIDTH-1){1'b0}}}; // signed zero
    end else begin
      special_o        = 1'b0; // both normal, run the divider
      special_result_o = '0;
    end
  end

endmodule

//--- src/fdiv_ctrl.sv
/*
  control of the divide unit
  ready FSM with flush, start acceptance
  sign and exponent capture, result and flag hold registers
  mask capture on start
*/

`timescale 1ns/100ps

module fdiv_ctrl import fdiv_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    start_i,
  input  logic    flush_i,
  input  fp32_t   a_i,
  input  fp32_t   b_i,
  input  logic    mask_i,
  input  logic    special_i,
  input  fp32_t   special_result_i,
  input  status_t special_status_i,
  input  logic    div_done_i,
  input  fp32_t   packed_result_i,
  input  status_t packed_status_i,
  output logic    div_start_o,
  output logic    div_abort_o,
  output logic    sign_o,
  output exp_t    exp_o,
  output logic    ready_o,
  output fp32_t   result_o,
  output status_t status_o,
  output logic    mask_o
);

  div_state_e state_q, state_d;
  logic       accept, finish;
  fp32_t      result_q;
  status_t    status_q;
  logic       mask_q, sign_q;
  exp_t       exp_q;

  assign ready_o     = state_q != BUSY;         // free in idle and hold
  assign accept      = start_i & ready_o;       // start while busy is dropped
  assign div_start_o = accept & ~special_i;
  assign div_abort_o = flush_i & (state_q == BUSY);
  assign finish      = (state_q == BUSY) & div_done_i & ~flush_i;

  // ----------------------------------------
  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      BUSY: begin
        if (flush_i) state_d = IDLE;          // abort, hold regs untouched
        else if (div_done_i) state_d = HOLD;
      end
      default: begin
        if (accept) state_d = special_i ? HOLD : BUSY; // specials finish at once
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      result_q <= '0;
      status_q <= '0;
      mask_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) mask_q <= mask_i;
      if (accept && special_i) begin
        result_q <= special_result_i;
        status_q <= special_status_i;
      end else if (finish) begin
        result_q <= packed_result_i;
        status_q <= packed_status_i;
      end
    end
  end

  // sign and exponent taken at start, operands may move on
  always_ff @(posedge clk_i) begin
    if (accept) begin
      sign_q <= a_i[WIDTH-1] ^ b_i[WIDTH-1];
      exp_q  <= exp_t'({2'b00, a_i[WIDTH-2 -: EXP_W]})
                - exp_t'({2'b00, b_i[WIDTH-2 -: EXP_W]}) + exp_t'(EXP_BIAS);
    end
  end

  assign sign_o   = sign_q;
  assign exp_o    = exp_q;
  assign result_o = result_q;
  assign status_o = status_q;
  assign mask_o   = mask_q;

endmodule

//--- src/fdiv_mant_divider.sv
/*
  iterative restoring divider for the significands
  one quotient bit per cycle, QUOT_W cycles per run
  sticky from the final remainder, abort stops a run
*/

`timescale 1ns/100ps

module fdiv_mant_divider import fdiv_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  start_i,
  input  logic  abort_i,
  input  mant_t dividend_i,
  input  mant_t divisor_i,
  output logic  done_o,
  output quot_t quot_o,
  output logic  sticky_o
);

  logic [$clog2(QUOT_W)-1:0] cnt_q;
  logic                      run_q, done_q;
  logic [MAN_W+1:0]          rem_q;   // partial remainder, always below 2 * divisor
  mant_t                     div_q;   // divisor kept for the whole run
  quot_t                     quot_q;
  logic [MAN_W+1:0]          diff;
  logic                      q_bit;

  // ----------------------------------------
  // trial subtraction
  assign diff  = rem_q - {1'b0, div_q};
  assign q_bit = rem_q >= {1'b0, div_q};

  // control state
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (abort_i) begin
      run_q  <= 1'b0; // flush, drop the run
      done_q <= 1'b0;
    end else if (start_i) begin
      run_q  <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0; // single cycle pulse
      if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == $bits(cnt_q)'(QUOT_W - 1)) begin
          run_q  <= 1'b0;
          done_q <= 1'b1; // last bit lands with this edge
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_q  <= {1'b0, dividend_i};
      div_q  <= divisor_i;
      quot_q <= '0;
    end else if (run_q) begin
      quot_q <= {quot_q[QUOT_W-2:0], q_bit};
      rem_q  <= q_bit ? {diff[MAN_W:0], 1'b0} : {rem_q[MAN_W:0], 1'b0};
    end
  end

  assign done_o   = done_q;
  assign quot_o   = quot_q;   // steady once the run ends
  assign sticky_o = |rem_q;

endmodule

//--- src/fdiv_pipe_regs.sv
/*
  chain of enabled register stages
  one enable bit per stage, zero stages pass straight through
*/

`timescale 1ns/100ps

module fdiv_pipe_regs import fdiv_pkg::*; #(
  parameter int unsigned NumStages = 1,
  parameter int unsigned DataW     = WIDTH
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [NumStages-1:0] en_i,
  input  logic [DataW-1:0]     data_i,
  output logic [DataW-1:0]     data_o
);

  // index i holds the data after i stages
  logic [DataW-1:0] pipe_q [NumStages+1];

  assign pipe_q[0] = data_i;

  for (genvar i = 0; i < NumStages; i++) begin : gen_stage
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        pipe_q[i+1] <= '0;
      end else if (en_i[i]) begin // low enable freezes the stage
        pipe_q[i+1] <= pipe_q[i];
      end
    end
  end

  assign data_o = pipe_q[NumStages];

endmodule

//--- src/fdiv_pkg.sv
/*
  fp32 divide unit package
  float field widths, bias and the quiet nan pattern
  quotient width and pipeline stage counts
  word, significand, quotient, exponent and flag types
  control state enum
*/

package fdiv_pkg;

  // ----------------------------------------
  // float format
  localparam int unsigned WIDTH    = 32;
  localparam int unsigned EXP_W    = 8;
  localparam int unsigned MAN_W    = 23;
  localparam int unsigned EXP_BIAS = 127;

  // 24 significand bits + normalization bit + guard bit
  localparam int unsigned QUOT_W = 26;

  // ----------------------------------------
  // pipeline stages around the unit
  localparam int unsigned NUM_INP_REGS  = 1;
  localparam int unsigned NUM_OUT_REGS  = 1;
  localparam int unsigned NUM_PIPE_REGS = NUM_INP_REGS + NUM_OUT_REGS;

  localparam logic [WIDTH-1:0] CANON_NAN = 32'h7fc0_0000; // quiet nan, positive

  typedef logic [WIDTH-1:0]      fp32_t;
  typedef logic [MAN_W:0]        mant_t;   // hidden bit on top
  typedef logic [QUOT_W-1:0]     quot_t;
  typedef logic signed [9:0]     exp_t;    // room for over/underflow
  typedef logic [4:0]            status_t; // nv dz of uf nx

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    HOLD
  } div_state_e;

endpackage

//--- src/fdiv_round_pack.sv
/*
  normalization, round to nearest even and packing
  exponent adjust for the quotient range [0.5, 2)
  overflow to infinity, tiny results flush to zero
*/

`timescale 1ns/100ps

module fdiv_round_pack import fdiv_pkg::*; (
  input  logic    sign_i,
  input  exp_t    exp_i,    // biased exponent difference
  input  quot_t   quot_i,
  input  logic    sticky_i,
  output fp32_t   result_o,
  output status_t status_o
);

  mant_t            sig;
  logic             guard, sticky, round_up, inexact;
  exp_t             exp_n, exp_r;
  logic [MAN_W+1:0] sig_rnd;  // one extra bit for the carry out
  logic [MAN_W-1:0] frac;

  // ----------------------------------------
  // normalize by at most one bit
  always_comb begin
    if (quot_i[QUOT_W-1]) begin
      sig    = quot_i[QUOT_W-1:2];
      guard  = quot_i[1];
      sticky = quot_i[0] | sticky_i; // low bit drops into sticky
      exp_n  = exp_i;
    end else begin
      sig    = quot_i[QUOT_W-2:1];
      guard  = quot_i[0];
      sticky = sticky_i;
      exp_n  = exp_i - exp_t'(1); // quotient below one
    end
  end

  // ----------------------------------------
  // rne, ties go to the even significand
  assign round_up = guard & (sticky | sig[0]);
  assign sig_rnd  = {1'b0, sig} + {{(MAN_W+1){1'b0}}, round_up};
  assign inexact  = guard | sticky;

  // carry out of rounding gives 1.000..0 with exponent + 1
  assign exp_r = exp_n + exp_t'(sig_rnd[MAN_W+1]);
  assign frac  = sig_rnd[MAN_W+1] ? sig_rnd[MAN_W:1] : sig_rnd[MAN_W-1:0];

  // ----------------------------------------
  // packing and range limits
  always_comb begin
    result_o = {sign_i, exp_r[EXP_W-1:0], frac};
    status_o = {4'b0000, inexact};
    if (exp_r > exp_t'(2 * EXP_BIAS)) begin
      result_o = {sign_i, {EXP_W{1'b1}}, {MAN_W{1'b0}}}; // signed inf
      status_o = 5'b00101;                                // of, nx
    end else if (exp_r < exp_t'(1)) begin
      result_o = {sign_i, {(WIDTH-1){1'b0}}};             // flush to zero
      status_o = 5'b00011;                                // uf, nx
    end
  end

endmodule

//--- src/fdiv_top.sv
/*
  fp32 divide unit top level
  input register stage, classification, control, mantissa divider,
  rounding and packing, output register stage
*/

`timescale 1ns/100ps

module fdiv_top import fdiv_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fp32_t [1:0]              operands_i,   // 0 dividend, 1 divisor
  input  logic                     mask_i,
  input  logic [NUM_PIPE_REGS-1:0] reg_enable_i,
  input  logic                     fsm_start_i,
  input  logic                     flush_i,
  output fp32_t                    result_o,
  output status_t                  status_o,
  output logic                     mask_o,
  output logic                     fsm_ready_o
);

  fp32_t   op_a, op_b, special_result, packed_result, held_result;
  logic    op_mask, special, div_start, div_abort, div_done, sticky;
  logic    sign, held_mask;
  status_t special_status, packed_status, held_status;
  exp_t    exp_diff;
  quot_t   quot;

  // ----------------------------------------
  // input stage, operands and mask
  fdiv_pipe_regs #(.NumStages(NUM_INP_REGS), .DataW(2 * WIDTH + 1)) u_inp_pipe (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .en_i    (reg_enable_i[NUM_INP_REGS-1:0]),
    .data_i  ({mask_i, operands_i[1], operands_i[0]}),
    .data_o  ({op_mask, op_b, op_a})
  );

  fdiv_classify u_classify (
    .a_i (op_a), .b_i (op_b), .special_o (special),
    .special_result_o (special_result), .special_status_o (special_status)
  );

  fdiv_ctrl u_ctrl (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .start_i (fsm_start_i), .flush_i (flush_i),
    .a_i (op_a), .b_i (op_b), .mask_i (op_mask), .special_i (special),
    .special_result_i (special_result), .special_status_i (special_status),
    .div_done_i (div_done), .packed_result_i (packed_result),
    .packed_status_i (packed_status), .div_start_o (div_start),
    .div_abort_o (div_abort), .sign_o (sign), .exp_o (exp_diff),
    .ready_o (fsm_ready_o), .result_o (held_result), .status_o (held_status),
    .mask_o (held_mask)
  );

  // significands with the hidden bit restored
  fdiv_mant_divider u_divider (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .start_i (div_start), .abort_i (div_abort),
    .dividend_i ({1'b1, op_a[MAN_W-1:0]}), .divisor_i ({1'b1, op_b[MAN_W-1:0]}),
    .done_o (div_done), .quot_o (quot), .sticky_o (sticky)
  );

  fdiv_round_pack u_round_pack (
    .sign_i (sign), .exp_i (exp_diff), .quot_i (quot), .sticky_i (sticky),
    .result_o (packed_result), .status_o (packed_status)
  );

  // output stage, held result, flags and mask
  fdiv_pipe_regs #(.NumStages(NUM_OUT_REGS), .DataW(WIDTH + 6)) u_out_pipe (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .en_i    (reg_enable_i[NUM_PIPE_REGS-1:NUM_INP_REGS]),
    .data_i  ({held_mask, held_status, held_result}),
    .data_o  ({mask_o, status_o, result_o})
  );

endmodule

//--- test/fdiv_chk.sv
/*
  control timing assertions for the divide unit
  bound into the top level
*/

`timescale 1ns/100ps

module fdiv_chk import fdiv_pkg::*; (
  input logic clk_i,
  input logic rst_n_i,
  input logic start_i,
  input logic flush_i,
  input logic special_i,
  input logic ready_i
);

  logic [5:0] low_cnt_q; // cycles with ready low

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || ready_i) begin
      low_cnt_q <= '0;
    end else begin
      low_cnt_q <= low_cnt_q + 6'd1;
    end
  end

  // ----------------------------------------
  // properties
  assert property (@(posedge clk_i) !rst_n_i |=> ready_i)
    else $error("ready low right after reset");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i && ready_i && !special_i |=> !ready_i)
    else $error("normal start did not drop ready");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i && !ready_i |=> ready_i)
    else $error("flush did not bring ready back");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    low_cnt_q <= 6'(QUOT_W + 1))
    else $error("ready low for too long");

endmodule

bind fdiv_top fdiv_chk u_fdiv_chk (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .start_i   (fsm_start_i),
  .flush_i   (flush_i),
  .special_i (special),
  .ready_i   (fsm_ready_o)
);

//--- test/fdiv_tb.sv
/*
  testbench for the fp32 divide unit
  clock, reset, stimulus table with expected results and flags
  per-row loop with xorshift mask bits, flush row, timeout
  per-row report and closing counts
*/

`timescale 1ns/100ps

module fdiv_tb import fdiv_pkg::*; ();

  localparam int NUM_ROWS   = 15;
  localparam int MAX_CYCLES = NUM_ROWS * 40 + 50; // ~31 cycles per row worst case

  // one table row
  typedef struct packed {
    fp32_t   a;      // dividend
    fp32_t   b;      // divisor
    fp32_t   res;    // expected result
    status_t st;     // expected nv dz of uf nx
    logic    flush;  // abort the run midway
  } row_t;

  logic                     clk;
  logic                     rst_n;
  fp32_t [1:0]              operands;
  logic                     mask;
  logic [NUM_PIPE_REGS-1:0] reg_enable;
  logic                     fsm_start;
  logic                     flush;
  fp32_t                    result;
  status_t                  status;
  logic                     mask_out;
  logic                     ready;

  row_t        rows [NUM_ROWS];
  logic [31:0] rng;
  int          n_checks;
  int          n_errors;
  int          cycles;
  logic        row_bad;

  fdiv_top fdiv_top_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .operands_i   (operands),
    .mask_i       (mask),
    .reg_enable_i (reg_enable),
    .fsm_start_i  (fsm_start),
    .flush_i      (flush),
    .result_o     (result),
    .status_o     (status),
    .mask_o       (mask_out),
    .fsm_ready_o  (ready)
  );

  always #10 clk = ~clk; // 20 ns period

  // ----------------------------------------
  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the unit never became ready again", cycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      row_bad = 1'b1;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // ----------------------------------------
  // stimulus table
  task automatic fill_table();
    rows[0]  = {32'h40c0_0000, 32'h4000_0000, 32'h4040_0000, 5'b00000, 1'b0}; // 6 / 2
    rows[1]  = {32'h3f80_0000, 32'h4080_0000, 32'h3e80_0000, 5'b00000, 1'b0}; // 1 / 4
    rows[2]  = {32'hc110_0000, 32'h4040_0000, 32'hc040_0000, 5'b00000, 1'b0}; // -9 / 3
    rows[3]  = {32'h3f80_0000, 32'h4040_0000, 32'h3eaa_aaab, 5'b00001, 1'b0}; // 1 / 3
    rows[4]  = {32'h4000_0000, 32'h4040_0000, 32'h3f2a_aaab, 5'b00001, 1'b0}; // 2 / 3
    rows[5]  = {32'h3f80_0000, 32'h40e0_0000, 32'h3e12_4925, 5'b00001, 1'b0}; // 1 / 7
    // 5 / 3 aborted, held result stays at 1 / 7
    rows[6]  = {32'h40a0_0000, 32'h4040_0000, 32'h3e12_4925, 5'b00001, 1'b1};
    rows[7]  = {32'h40e0_0000, 32'h4000_0000, 32'h4060_0000, 5'b00000, 1'b0}; // 7 / 2
    rows[8]  = {32'h3f80_0000, 32'h0000_0000, 32'h7f80_0000, 5'b01000, 1'b0}; // 1 / 0
    rows[9]  = {32'h0000_0000, 32'h0000_0000, 32'h7fc0_0000, 5'b10000, 1'b0}; // 0 / 0
    rows[10] = {32'h7f80_0001, 32'h4000_0000, 32'h7fc0_0000, 5'b10000, 1'b0}; // snan / 2
    rows[11] = {32'h7f80_0000, 32'h4000_0000, 32'h7f80_0000, 5'b00000, 1'b0}; // inf / 2
    rows[12] = {32'h4040_0000, 32'h7f80_0000, 32'h0000_0000, 5'b00000, 1'b0}; // 3 / inf
    rows[13] = {32'h7f00_0000, 32'h3e80_0000, 32'h7f80_0000, 5'b00101, 1'b0}; // overflow
    rows[14] = {32'h0080_0000, 32'h4b00_0000, 32'h0000_0000, 5'b00011, 1'b0}; // underflow
  endtask

  // one division from operand drive to output check
  task automatic run_row(input int idx);
    row_t r;
    logic mask_bit;
    r = rows[idx];
    row_bad = 1'b0;
    rng = xorshift32(rng);
    mask_bit = rng[0];
    @(negedge clk);
    operands[0] = r.a;
    operands[1] = r.b;
    mask = mask_bit;   // travels with the operands through the input stage
    @(negedge clk);
    fsm_start = 1'b1;  // operands now at the input stage output
    @(negedge clk);
    fsm_start = 1'b0;
    if (r.flush) begin
      repeat (4) @(negedge clk);
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      compare_value("ready after flush", {31'b0, ready}, 32'd1);
    end
    while (!ready) @(negedge clk);
    @(negedge clk);    // output stage
    compare_value("result", result, r.res);
    compare_value("status", {27'b0, status}, {27'b0, r.st});
    compare_value("mask", {31'b0, mask_out}, {31'b0, mask_bit});
    $display("row %2d  %h / %h -> %h  %s", idx, r.a, r.b, result,
             row_bad ? "mismatch" : "ok");
  endtask

  // ----------------------------------------
  // main sequence
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    operands   = '0;
    mask       = 1'b0;
    reg_enable = '1;   // stages always enabled
    fsm_start  = 1'b0;
    flush      = 1'b0;
    rng        = 32'd74;
    n_checks   = 0;
    n_errors   = 0;
    cycles     = 0;
    row_bad    = 1'b0;
    fill_table();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
